/* filelist.f */
+incdir+verification
hdl/st_io_pkg.sv
hdl/st_video_pkg.sv
hdl/byte_fifo.sv
hdl/host_ctrl_regs.sv
hdl/printer_port.sv
hdl/video_out_pipe.sv
hdl/mistery_io_top.sv
verification/tb_mistery_io.sv

/* hdl/byte_fifo.sv */
// Synchronous byte FIFO
// Circular buffer, read/write pointers and occupancy count
// Head byte visible without a pop
`timescale 1ns/1ps

module byte_fifo #(
	parameter int DEPTH = 16
) (
	input  logic       clk_96,
	input  logic       rst_n,
	input  logic       push,
	input  logic [7:0] din,
	input  logic       pop,
	output logic [7:0] dout,  // Oldest byte
	output logic       full,
	output logic       empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [7:0]    mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          push_ok; // Push not dropped
	logic          pop_ok;  // Pop not ignored

	assign push_ok = push & ~full;
	assign pop_ok  = pop & ~empty;

	assign full  = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign dout  = mem[rd_ptr];

	// Storage
	always_ff @(posedge clk_96) begin
		if (push_ok) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk_96 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0; // Empty after reset
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

/* hdl/host_ctrl_regs.sv */
// AXI4-Lite slave on the host side
// Holds the system control word, byte-strobe writes
// MIDI and printer FIFO drain through read-to-pop registers
`timescale 1ns/1ps

module host_ctrl_regs (
	input  logic                  clk_96,
	input  logic                  rst_n,
	// Write address / data / response
	input  st_io_pkg::axil_addr_t awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [31:0]           wdata,
	input  logic [3:0]            wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	// Read address / data
	input  st_io_pkg::axil_addr_t araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [31:0]           rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,
	// Decoded side
	output st_io_pkg::sys_ctrl_t  ctrl,        // To printer port and video
	input  logic [7:0]            midi_data,   // MIDI FIFO head
	input  logic                  midi_empty,
	input  logic [7:0]            prn_data,    // Printer FIFO head
	input  logic                  prn_empty,
	output logic                  midi_pop,    // One-cycle pulses
	output logic                  prn_pop
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic                 wr_accept;   // AW and W taken this cycle
	logic                 wr_is_ctrl;
	logic [31:0]          ctrl_merged; // Word after strobe merge
	logic                 rd_accept;
	logic [31:0]          rd_data_nxt;
	logic [1:0]           rd_resp_nxt;
	st_io_pkg::pop_data_t pop_reply;

	// Both channels must be valid, one outstanding response max
	assign wr_accept  = awvalid & wvalid & ~bvalid;
	assign awready    = wr_accept;
	assign wready     = wr_accept;
	assign wr_is_ctrl = (st_io_pkg::reg_addr_e'(awaddr) == st_io_pkg::CTRL);

	// Byte lanes from wdata where strobed, else keep
	always_comb begin
		ctrl_merged = ctrl;
		for (int i = 0; i < 4; i++) begin
			if (wstrb[i]) begin
				ctrl_merged[8*i +: 8] = wdata[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk_96 or negedge rst_n) begin
		if (!rst_n) begin
			ctrl   <= '0; // Core out of reset, nothing redirected
			bvalid <= 1'b0;
		end else begin
			if (wr_accept) begin
				bvalid <= 1'b1;
				if (wr_is_ctrl) begin
					ctrl <= st_io_pkg::sys_ctrl_t'(ctrl_merged);
				end
			end else if (bready) begin
				bvalid <= 1'b0; // Response taken
			end
		end
	end

	// Only CTRL is writable
	always_ff @(posedge clk_96) begin
		if (wr_accept) begin
			bresp <= wr_is_ctrl ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Read side, address taken whenever no data is waiting
	assign arready   = ~rvalid;
	assign rd_accept = arvalid & ~rvalid;

	// Reply mux and pop strobes
	always_comb begin
		pop_reply   = '0;
		rd_data_nxt = '0;
		rd_resp_nxt = RESP_OKAY;
		midi_pop    = 1'b0;
		prn_pop     = 1'b0;
		case (st_io_pkg::reg_addr_e'(araddr))
			st_io_pkg::CTRL: begin
				rd_data_nxt = ctrl;
			end
			st_io_pkg::MIDI_POP: begin
				if (!midi_empty) begin
					pop_reply.valid = 1'b1;
					pop_reply.data  = midi_data;
					midi_pop        = rd_accept; // Pop with the accept
				end
				rd_data_nxt = {23'd0, pop_reply}; // Reply in bits 8:0
			end
			st_io_pkg::PRN_POP: begin
				if (!prn_empty) begin
					pop_reply.valid = 1'b1;
					pop_reply.data  = prn_data;
					prn_pop         = rd_accept;
				end
				rd_data_nxt = {23'd0, pop_reply};
			end
			default: begin
				rd_resp_nxt = RESP_SLVERR; // Unmapped, data stays 0
			end
		endcase
	end

	always_ff @(posedge clk_96 or negedge rst_n) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (rd_accept) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// Reply held until rready
	always_ff @(posedge clk_96) begin
		if (rd_accept) begin
			rdata <= rd_data_nxt;
			rresp <= rd_resp_nxt;
		end
	end

endmodule

/* hdl/mistery_io_top.sv */
// Glue between the Atari ST core and the host I/O controller
// Control register block, MIDI output FIFO, printer port
// Video output pipeline towards the scaler
`timescale 1ns/1ps

module mistery_io_top #(
	parameter int MIDI_DEPTH = 16,
	parameter int PRN_DEPTH  = 4
) (
	input  logic                       clk_96,
	input  logic                       rst_n,
	// Host AXI4-Lite
	input  st_io_pkg::axil_addr_t      awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [31:0]                wdata,
	input  logic [3:0]                 wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  st_io_pkg::axil_addr_t      araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [31:0]                rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,
	// Core side
	input  logic                       midi_out_strobe, // ACIA data write
	input  logic [7:0]                 midi_out,
	input  logic                       parallel_out_strobe,
	input  logic [7:0]                 parallel_out,
	input  st_io_pkg::joy_t            joy2,
	input  st_io_pkg::joy_t            joy3,
	input  st_video_pkg::pixel_t       st_pix,
	input  logic                       blank_n,
	input  logic                       monomode,
	input  logic                       viking_active,
	input  st_video_pkg::pixel_t       viking_pix,
	output logic                       core_reset,
	output logic [1:0]                 fdc_wp,
	output logic                       parallel_printer_busy,
	output logic [7:0]                 parallel_in,
	output logic                       parallel_in_strobe,
	output st_video_pkg::pixel_t       vid_pix,
	output st_video_pkg::scaler_ctrl_t scaler
);

	st_io_pkg::sys_ctrl_t ctrl;
	logic [7:0]           midi_data;
	logic                 midi_empty;
	logic                 midi_pop;
	logic [7:0]           prn_data;
	logic                 prn_empty;
	logic                 prn_pop;

	assign core_reset = ctrl.core_reset;
	assign fdc_wp     = ctrl.fdc_wp;

	host_ctrl_regs i_regs (
		.clk_96     (clk_96),
		.rst_n      (rst_n),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.ctrl       (ctrl),
		.midi_data  (midi_data),
		.midi_empty (midi_empty),
		.prn_data   (prn_data),
		.prn_empty  (prn_empty),
		.midi_pop   (midi_pop),
		.prn_pop    (prn_pop)
	);

	// MIDI bytes to the host, overflow simply dropped
	byte_fifo #(
		.DEPTH (MIDI_DEPTH)
	) i_midi_fifo (
		.clk_96 (clk_96),
		.rst_n  (rst_n),
		.push   (midi_out_strobe),
		.din    (midi_out),
		.pop    (midi_pop),
		.dout   (midi_data),
		.full   (),
		.empty  (midi_empty)
	);

	printer_port #(
		.PRN_DEPTH (PRN_DEPTH)
	) i_printer (
		.clk_96                (clk_96),
		.rst_n                 (rst_n),
		.ctrl                  (ctrl),
		.parallel_out_strobe   (parallel_out_strobe),
		.parallel_out          (parallel_out),
		.prn_pop               (prn_pop),
		.prn_data              (prn_data),
		.prn_empty             (prn_empty),
		.joy2                  (joy2),
		.joy3                  (joy3),
		.parallel_printer_busy (parallel_printer_busy),
		.parallel_in           (parallel_in),
		.parallel_in_strobe    (parallel_in_strobe)
	);

	video_out_pipe i_video (
		.clk_96        (clk_96),
		.rst_n         (rst_n),
		.ctrl          (ctrl),
		.st_pix        (st_pix),
		.blank_n       (blank_n),
		.monomode      (monomode),
		.viking_active (viking_active),
		.viking_pix    (viking_pix),
		.vid_pix       (vid_pix),
		.scaler        (scaler)
	);

endmodule

/* hdl/printer_port.sv */
// Printer side of the ST parallel port
// Output byte FIFO towards the host, busy source select
// Extra joysticks mapped onto parallel input, Gauntlet style
`timescale 1ns/1ps

module printer_port #(
	parameter int PRN_DEPTH = 4
) (
	input  logic                 clk_96,
	input  logic                 rst_n,
	input  st_io_pkg::sys_ctrl_t ctrl,
	input  logic                 parallel_out_strobe, // PSG port B write
	input  logic [7:0]           parallel_out,
	input  logic                 prn_pop,
	output logic [7:0]           prn_data,
	output logic                 prn_empty,
	input  st_io_pkg::joy_t      joy2,
	input  st_io_pkg::joy_t      joy3,
	output logic                 parallel_printer_busy,
	output logic [7:0]           parallel_in,
	output logic                 parallel_in_strobe
);

	logic prn_full;

	byte_fifo #(
		.DEPTH (PRN_DEPTH)
	) i_prn_fifo (
		.clk_96 (clk_96),
		.rst_n  (rst_n),
		.push   (parallel_out_strobe),
		.din    (parallel_out),
		.pop    (prn_pop),
		.dout   (prn_data),
		.full   (prn_full),
		.empty  (prn_empty)
	);

	// Busy from FIFO when printing to host, else joystick 2 fire on MFP I0
	assign parallel_printer_busy =
		(ctrl.redirection == st_io_pkg::PRINTER) ? prn_full : joy2.fire;

	// Active low lines, joy2 in the high nibble
	assign parallel_in = {~joy2.right, ~joy2.left, ~joy2.down, ~joy2.up,
		~joy3.right, ~joy3.left, ~joy3.down, ~joy3.up};
	assign parallel_in_strobe = ~joy3.fire; // Joy3 fire on strobe

endmodule

/* hdl/st_io_pkg.sv */
// Host-side I/O types
// AXI4-Lite address, register map and USB redirection encoding
// System control word layout, FIFO pop reply, joystick bits

package st_io_pkg;

	typedef logic [3:0] axil_addr_t; // Byte address, 4 regs max

	// Register offsets
	typedef enum logic [3:0] {
		CTRL     = 4'h0, // R/W system control word
		MIDI_POP = 4'h4, // RO, pops MIDI FIFO
		PRN_POP  = 4'h8  // RO, pops printer FIFO
	} reg_addr_e;

	// Target of the io controller's USB port
	typedef enum logic [1:0] {
		NONE    = 2'd0,
		RS232   = 2'd1,
		PRINTER = 2'd2,
		MIDI    = 2'd3
	} redir_e;

	// 32-bit system control word, MSB first
	typedef struct packed {
		logic [1:0]  rsvd_31_30;
		logic        blend;       // Bit 29
		logic        rsvd_28;
		redir_e      redirection; // Bits 27:26
		logic [3:0]  rsvd_25_22;
		logic [1:0]  scanlines;   // Bits 21:20
		logic [11:0] rsvd_19_8;
		logic [1:0]  fdc_wp;      // Bits 7:6, one per drive
		logic [4:0]  rsvd_5_1;
		logic        core_reset;  // Bit 0
	} sys_ctrl_t;

	typedef struct packed {
		logic       valid; // Byte present
		logic [7:0] data;
	} pop_data_t;

	// Low joystick bits, fire on top
	typedef struct packed {
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

endpackage

/* hdl/st_video_pkg.sv */
// Video-side types
// Colour depth per channel
// Pixel bundle with syncs, scaler control flags

package st_video_pkg;

	parameter int COLOR_BITS = 4; // ST palette depth

	// One pixel plus its syncs, 14 bits
	typedef struct packed {
		logic [COLOR_BITS-1:0] r;
		logic [COLOR_BITS-1:0] g;
		logic [COLOR_BITS-1:0] b;
		logic                  hsync_n;
		logic                  vsync_n;
	} pixel_t;

	// Flags for the downstream scaler / scandoubler
	typedef struct packed {
		logic       blend;           // Horizontal blend on
		logic       scandoubler_off; // Bypass doubler
		logic       no_csync;        // Separate syncs
		logic [1:0] scanlines;       // Scanline strength
	} scaler_ctrl_t;

	// Spare per-channel mask value
	typedef logic [COLOR_BITS-1:0] color_t;

endpackage

/* hdl/video_out_pipe.sv */
// Video output pipeline, two stages
// Stage 1 ST shifter / Viking select and blanking
// Stage 2 pixel register and scaler control flags
`timescale 1ns/1ps

module video_out_pipe (
	input  logic                        clk_96,
	input  logic                        rst_n,
	input  st_io_pkg::sys_ctrl_t        ctrl,
	input  st_video_pkg::pixel_t        st_pix,        // ST shifter
	input  logic                        blank_n,
	input  logic                        monomode,      // SM124 hi-res
	input  logic                        viking_active,
	input  st_video_pkg::pixel_t        viking_pix,    // Viking card
	output st_video_pkg::pixel_t        vid_pix,
	output st_video_pkg::scaler_ctrl_t  scaler
);

	st_video_pkg::pixel_t sel_pix;   // Stage 1 input
	st_video_pkg::pixel_t s1_pix;
	logic                 s1_mono;
	logic                 s1_viking;
	logic                 s1_nodbl;  // Mono or Viking, no doubling

	// Source select and blanking
	always_comb begin
		if (viking_active) begin
			sel_pix = viking_pix;
		end else begin
			sel_pix = st_pix;
			if (!blank_n && !monomode) begin
				// Colour off in the border, syncs kept
				sel_pix.r = '0;
				sel_pix.g = '0;
				sel_pix.b = '0;
			end
		end
	end

	// Stage 1
	always_ff @(posedge clk_96 or negedge rst_n) begin
		if (!rst_n) begin
			s1_pix    <= '0;
			s1_mono   <= 1'b0;
			s1_viking <= 1'b0;
		end else begin
			s1_pix    <= sel_pix;
			s1_mono   <= monomode;
			s1_viking <= viking_active;
		end
	end

	assign s1_nodbl = s1_mono | s1_viking;

	// Stage 2, flags aligned with the pixel
	always_ff @(posedge clk_96 or negedge rst_n) begin
		if (!rst_n) begin
			vid_pix <= '0;
			scaler  <= '0;
		end else begin
			vid_pix                <= s1_pix;
			scaler.blend           <= ctrl.blend & ~s1_nodbl; // Only ST low/mid res
			scaler.scandoubler_off <= s1_nodbl; // Already VGA rate
			scaler.no_csync        <= s1_nodbl;
			scaler.scanlines       <= ctrl.scanlines;
		end
	end

endmodule

/* verification/tb_mistery_io_tests.svh */
// Directed tests for the ST I/O glue
// Control word, MIDI FIFO, printer port, video pipe, bus errors
// Byte push helpers and FIFO pop-and-compare
`ifndef TB_MISTERY_IO_TESTS_SVH
`define TB_MISTERY_IO_TESTS_SVH

	// Strobed bytes from data, others kept
	function automatic logic [31:0] merge_strobes(input logic [31:0] old,
			input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}}; // Lane enables
		return (data & mask) | (old & ~mask);
	endfunction

	// One byte from the core, one cycle of strobe
	task automatic push_core_byte(input logic to_printer, input logic [7:0] b);
		if (to_printer) begin
			parallel_out        = b;
			parallel_out_strobe = 1'b1;
		end else begin
			midi_out        = b;
			midi_out_strobe = 1'b1;
		end
		@(posedge clk_96);
		#2;
		parallel_out_strobe = 1'b0;
		midi_out_strobe     = 1'b0;
	endtask

	// Read a pop register, oldest queued byte or empty reply
	task automatic pop_and_check(input st_io_pkg::axil_addr_t addr, input string name,
			input int r_wait, ref logic [7:0] q[$]);
		st_io_pkg::pop_data_t exp;
		logic [31:0]          rd;
		logic [1:0]           resp;
		exp = '0;
		if (q.size() > 0) begin
			exp.valid = 1'b1;
			exp.data  = q.pop_front();
		end
		axil_read(addr, r_wait, rd, resp);
		check_pop(name, exp, rd[8:0]);
		check_word({name, " upper bits"}, 32'd0, {rd[31:9], 9'd0});
		check_resp(name, OKAY, resp);
	endtask

	task automatic test_ctrl_reg();
		logic [31:0] rd;
		logic [31:0] wd;
		logic [1:0]  resp;
		int          err0;
		err0 = n_errors;
		axil_read(st_io_pkg::CTRL, 0, rd, resp);
		check_ctrl("ctrl after reset", '0, rd);
		check_resp("ctrl read", OKAY, resp);
		check_bit("core_reset after reset", 1'b0, core_reset);
		wd    = $urandom;
		wd[0] = 1'b1; // Core reset on
		axil_write(st_io_pkg::CTRL, wd, 4'b0101, 0, resp);
		ctrl_model = merge_strobes(ctrl_model, wd, 4'b0101);
		check_resp("ctrl write", OKAY, resp);
		check_bit("core_reset", ctrl_model[0], core_reset);
		check_bit("fdc_wp[0]", ctrl_model[6], fdc_wp[0]);
		check_bit("fdc_wp[1]", ctrl_model[7], fdc_wp[1]);
		check_bit("scaler.scanlines[0]", ctrl_model[20], scaler.scanlines[0]);
		check_bit("scaler.scanlines[1]", ctrl_model[21], scaler.scanlines[1]);
		wd     = $urandom;
		wd[29] = 1'b1; // Blend, top byte only
		axil_write(st_io_pkg::CTRL, wd, 4'b1000, 2, resp);
		ctrl_model = merge_strobes(ctrl_model, wd, 4'b1000);
		check_bit("scaler.blend", ctrl_model[29], scaler.blend); // ST source, no mono
		check_bit("core_reset kept", ctrl_model[0], core_reset);
		axil_read(st_io_pkg::CTRL, 0, rd, resp);
		check_ctrl("ctrl readback", ctrl_model, rd);
		// Release the core again
		axil_write(st_io_pkg::CTRL, 32'd0, 4'b0001, 0, resp);
		ctrl_model = merge_strobes(ctrl_model, 32'd0, 4'b0001);
		check_bit("core_reset released", 1'b0, core_reset);
		finish_test("control register", err0);
	endtask

	task automatic test_midi_fifo();
		logic [7:0]  q[$];
		logic [31:0] rnd;
		int          err0;
		err0 = n_errors;
		for (int i = 0; i < 5; i++) begin
			rnd = $urandom;
			push_core_byte(1'b0, rnd[7:0]);
			q.push_back(rnd[7:0]);
		end
		for (int i = 0; i < 6; i++) begin
			pop_and_check(st_io_pkg::MIDI_POP, "midi pop", 0, q); // Sixth is empty
		end
		// Back-to-back pushes past the 16-byte depth
		for (int i = 0; i < 18; i++) begin
			rnd = $urandom;
			push_core_byte(1'b0, rnd[7:0]);
			if (q.size() < 16) begin
				q.push_back(rnd[7:0]);
			end
		end
		for (int i = 0; i < 17; i++) begin
			pop_and_check(st_io_pkg::MIDI_POP, "midi pop after overflow", 0, q);
		end
		finish_test("MIDI FIFO", err0);
	endtask

	task automatic test_printer();
		logic [7:0]  q[$];
		logic [7:0]  exp;
		logic [31:0] rnd;
		logic [1:0]  resp;
		int          err0;
		err0 = n_errors;
		ctrl_model[27:26] = 2'd2; // Redirect to printer
		axil_write(st_io_pkg::CTRL, ctrl_model, 4'hF, 0, resp);
		joy2 = 5'b10000; // Fire held, must not matter here
		for (int i = 0; i < 4; i++) begin
			check_bit("busy before full", 1'b0, parallel_printer_busy);
			rnd = $urandom;
			push_core_byte(1'b1, rnd[7:0]);
			q.push_back(rnd[7:0]);
		end
		check_bit("busy when full", 1'b1, parallel_printer_busy);
		pop_and_check(st_io_pkg::PRN_POP, "printer pop", 0, q);
		check_bit("busy after pop", 1'b0, parallel_printer_busy);
		while (q.size() > 0) begin
			pop_and_check(st_io_pkg::PRN_POP, "printer drain", 0, q);
		end
		ctrl_model[27:26] = 2'd0; // No redirection, busy from joystick
		axil_write(st_io_pkg::CTRL, ctrl_model, 4'hF, 0, resp);
		check_bit("busy from joy2 fire", 1'b1, parallel_printer_busy);
		joy2 = 5'b00000;
		@(posedge clk_96);
		#2;
		check_bit("busy from joy2 idle", 1'b0, parallel_printer_busy);
		for (int i = 0; i < 8; i++) begin
			rnd  = $urandom;
			joy2 = rnd[4:0];
			joy3 = rnd[12:8];
			@(posedge clk_96);
			#2;
			for (int k = 0; k < 4; k++) begin
				exp[7-k] = ~joy2[k]; // Right, left, down, up
				exp[3-k] = ~joy3[k];
			end
			check_byte("parallel_in", exp, parallel_in);
			check_bit("parallel_in_strobe", ~joy3[4], parallel_in_strobe);
		end
		finish_test("printer port", err0);
	endtask

	task automatic test_video();
		st_video_pkg::pixel_t       exp_pix[$];
		st_video_pkg::scaler_ctrl_t exp_scl[$];
		st_video_pkg::pixel_t       p;
		st_video_pkg::scaler_ctrl_t s;
		logic [31:0]                rnd;
		logic [1:0]                 resp;
		logic                       nodbl;
		int                         err0;
		err0              = n_errors;
		rnd               = $urandom;
		ctrl_model[29]    = 1'b1;
		ctrl_model[21:20] = rnd[1:0];
		axil_write(st_io_pkg::CTRL, ctrl_model, 4'hF, 0, resp);
		for (int i = 0; i < 40; i++) begin
			// Input from two cycles back reaches the outputs now
			if (i >= 2) begin
				check_pixel("vid_pix", exp_pix.pop_front(), vid_pix);
				check_scaler("scaler", exp_scl.pop_front(), scaler);
			end
			rnd           = $urandom;
			st_pix        = rnd[13:0];
			blank_n       = rnd[14];
			monomode      = (rnd[17:15] == 3'd0);
			viking_active = (rnd[20:18] == 3'd0);
			rnd           = $urandom;
			viking_pix    = rnd[13:0];
			if (viking_active) begin
				p = viking_pix;
			end else begin
				p = st_pix;
				if (!blank_n && !monomode) begin
					p.r = '0;
					p.g = '0;
					p.b = '0;
				end
			end
			nodbl             = monomode | viking_active;
			s.blend           = ctrl_model[29] & ~nodbl;
			s.scandoubler_off = nodbl;
			s.no_csync        = nodbl;
			s.scanlines       = ctrl_model[21:20];
			exp_pix.push_back(p);
			exp_scl.push_back(s);
			@(posedge clk_96);
			#2;
		end
		monomode      = 1'b0;
		viking_active = 1'b0;
		finish_test("video pipeline", err0);
	endtask

	task automatic test_bus_errors();
		logic [7:0]  q[$];
		logic [31:0] rd;
		logic [31:0] wd;
		logic [31:0] rnd;
		logic [1:0]  resp;
		int          err0;
		err0 = n_errors;
		axil_write(st_io_pkg::PRN_POP, 32'hFFFF_FFFF, 4'hF, 0, resp);
		check_resp("write to PRN_POP", SLVERR, resp);
		axil_read(st_io_pkg::CTRL, 0, rd, resp);
		check_ctrl("ctrl after bad write", ctrl_model, rd);
		axil_read(4'hC, 0, rd, resp);
		check_resp("read from 0xC", SLVERR, resp);
		check_word("rdata from 0xC", 32'd0, rd);
		// Late bready
		wd        = ctrl_model;
		wd[21:20] = ~wd[21:20];
		axil_write(st_io_pkg::CTRL, wd, 4'hF, 5, resp);
		ctrl_model = wd;
		check_resp("ctrl write, late bready", OKAY, resp);
		axil_read(st_io_pkg::CTRL, 3, rd, resp);
		check_ctrl("ctrl readback, late rready", ctrl_model, rd);
		// Late rready on a pop, one byte per accepted read
		for (int i = 0; i < 2; i++) begin
			rnd = $urandom;
			push_core_byte(1'b1, rnd[7:0]);
			q.push_back(rnd[7:0]);
		end
		pop_and_check(st_io_pkg::PRN_POP, "printer pop, late rready", 6, q);
		pop_and_check(st_io_pkg::PRN_POP, "printer pop, second byte", 0, q);
		pop_and_check(st_io_pkg::PRN_POP, "printer pop, empty", 0, q);
		finish_test("bus errors", err0);
	endtask

`endif

/* verification/tb_mistery_io.sv */
// Testbench top for the ST I/O glue
// Clock, reset, DUT instance, AXI4-Lite driver tasks
// Typed compare tasks, watchdog and run summary
`timescale 1ns/1ps

module tb_mistery_io;

	localparam int         CLK_NS      = 40;
	localparam int         TEST_CYCLES = 2000; // Rough sum of all test lengths
	localparam int         HS_LIMIT    = 20;   // Cycles allowed for a handshake
	localparam logic [1:0] OKAY        = 2'b00;
	localparam logic [1:0] SLVERR      = 2'b10;

	logic                       clk_96;
	logic                       rst_n;
	st_io_pkg::axil_addr_t      awaddr;
	logic                       awvalid;
	logic                       awready;
	logic [31:0]                wdata;
	logic [3:0]                 wstrb;
	logic                       wvalid;
	logic                       wready;
	logic [1:0]                 bresp;
	logic                       bvalid;
	logic                       bready;
	st_io_pkg::axil_addr_t      araddr;
	logic                       arvalid;
	logic                       arready;
	logic [31:0]                rdata;
	logic [1:0]                 rresp;
	logic                       rvalid;
	logic                       rready;
	logic                       midi_out_strobe;
	logic [7:0]                 midi_out;
	logic                       parallel_out_strobe;
	logic [7:0]                 parallel_out;
	st_io_pkg::joy_t            joy2;
	st_io_pkg::joy_t            joy3;
	st_video_pkg::pixel_t       st_pix;
	logic                       blank_n;
	logic                       monomode;
	logic                       viking_active;
	st_video_pkg::pixel_t       viking_pix;
	logic                       core_reset;
	logic [1:0]                 fdc_wp;
	logic                       parallel_printer_busy;
	logic [7:0]                 parallel_in;
	logic                       parallel_in_strobe;
	st_video_pkg::pixel_t       vid_pix;
	st_video_pkg::scaler_ctrl_t scaler;

	int          n_checks;
	int          n_errors;
	logic [31:0] ctrl_model; // Expected control word

	mistery_io_top #(
		.MIDI_DEPTH (16),
		.PRN_DEPTH  (4)
	) i_dut (.*);

	initial begin
		clk_96 = 1'b0;
		forever #(CLK_NS / 2) clk_96 = ~clk_96;
	end

	// Hard stop, twice the expected run length
	initial begin
		#(2 * TEST_CYCLES * CLK_NS);
		$display("Watchdog expired before the tests finished");
		$display("** FAIL **");
		$finish;
	end

	task automatic report_failure(input string msg);
		n_checks++;
		n_errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic check_ctrl(input string name, input st_io_pkg::sys_ctrl_t exp,
			input st_io_pkg::sys_ctrl_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_pop(input string name, input st_io_pkg::pop_data_t exp,
			input st_io_pkg::pop_data_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected valid %b data %h got valid %b data %h",
				$time, name, exp.valid, exp.data, act.valid, act.data);
		end
	endtask

	task automatic check_pixel(input string name, input st_video_pkg::pixel_t exp,
			input st_video_pkg::pixel_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_scaler(input string name, input st_video_pkg::scaler_ctrl_t exp,
			input st_video_pkg::scaler_ctrl_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// Called 2 ns after an edge, returns 2 ns after an edge
	task automatic axil_write(input st_io_pkg::axil_addr_t addr, input logic [31:0] data,
			input logic [3:0] strb, input int b_wait, output logic [1:0] resp);
		int n;
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wstrb   = strb;
		wvalid  = 1'b1;
		n       = 0;
		#1; // Ready lines are combinational
		while (!(awready && wready) && n < HS_LIMIT) begin
			@(posedge clk_96);
			#3;
			n++;
		end
		if (!(awready && wready)) begin
			report_failure("write address and data were never accepted");
			awvalid = 1'b0;
			wvalid  = 1'b0;
			resp    = 2'bxx;
		end else begin
			@(posedge clk_96); // Acceptance edge
			#2;
			awvalid = 1'b0;
			wvalid  = 1'b0;
			repeat (b_wait) begin
				check_bit("bvalid while bready low", 1'b1, bvalid);
				@(posedge clk_96);
				#2;
			end
			check_bit("bvalid", 1'b1, bvalid);
			resp   = bresp;
			bready = 1'b1;
			@(posedge clk_96);
			#2;
			bready = 1'b0;
		end
	endtask

	task automatic axil_read(input st_io_pkg::axil_addr_t addr, input int r_wait,
			output logic [31:0] data, output logic [1:0] resp);
		int n;
		araddr  = addr;
		arvalid = 1'b1;
		n       = 0;
		#1;
		while (!arready && n < HS_LIMIT) begin
			@(posedge clk_96);
			#3;
			n++;
		end
		if (!arready) begin
			report_failure("read address was never accepted");
			arvalid = 1'b0;
			data    = 'x;
			resp    = 2'bxx;
		end else begin
			@(posedge clk_96);
			#2;
			arvalid = 1'b0;
			repeat (r_wait) begin
				check_bit("rvalid while rready low", 1'b1, rvalid);
				check_bit("arready while rvalid high", 1'b0, arready);
				@(posedge clk_96);
				#2;
			end
			check_bit("rvalid", 1'b1, rvalid);
			data   = rdata;
			resp   = rresp;
			rready = 1'b1;
			@(posedge clk_96);
			#2;
			rready = 1'b0;
		end
	endtask

	task automatic finish_test(input string name, input int err0);
		$display("Test %s finished, %0d error(s)", name, n_errors - err0);
	endtask

	`include "tb_mistery_io_tests.svh"

	initial begin
		void'($urandom(32'h6296));
		n_checks            = 0;
		n_errors            = 0;
		ctrl_model          = '0;
		rst_n               = 1'b0;
		awaddr              = '0;
		awvalid             = 1'b0;
		wdata               = '0;
		wstrb               = '0;
		wvalid              = 1'b0;
		bready              = 1'b0;
		araddr              = '0;
		arvalid             = 1'b0;
		rready              = 1'b0;
		midi_out_strobe     = 1'b0;
		midi_out            = '0;
		parallel_out_strobe = 1'b0;
		parallel_out        = '0;
		joy2                = '0;
		joy3                = '0;
		st_pix              = '0;
		blank_n             = 1'b0;
		monomode            = 1'b0;
		viking_active       = 1'b0;
		viking_pix          = '0;
		repeat (8) @(posedge clk_96);
		#2;
		rst_n = 1'b1;
		@(posedge clk_96);
		#2;
		test_ctrl_reg();
		test_midi_fifo();
		test_printer();
		test_video();
		test_bus_errors();
		$display("Summary: %0d checks, %0d passed, %0d failed",
			n_checks, n_checks - n_errors, n_errors);
		if (n_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
